//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cnn_tail
RTL_TOP   ?= cnn_tail_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) cnn_tail_cfg.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- apb_regs.sv
`timescale 1ns/1ps
`include "cnn_tail_cfg.svh"

module apb_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_psel,
    input  logic                            i_penable,
    input  logic                            i_pwrite,
    input  logic [`CT_APB_AW-1:0]           i_paddr,
    input  logic [31:0]                     i_pwdata,
    output logic [31:0]                     o_prdata,
    output logic                            o_pready,
    output logic                            o_pslverr,
    input  cnn_tail_pkg::class_result_t     i_result,
    output cnn_tail_pkg::wgt_wr_t           o_wgt
);
    import cnn_tail_pkg::*;

    logic           access;
    logic           addr_hit;
    logic           wgt_en_q;
    logic [15:0]    wgt_bits_q;
    class_result_t  result_q;
    logic [31:0]    frame_cnt_q;

    assign access   = i_psel && i_penable;
    assign o_pready = 1'b1;

    always_comb begin
        case (i_paddr)
            REG_WGT, REG_RESULT, REG_STATUS: addr_hit = 1'b1;
            default:                         addr_hit = 1'b0;
        endcase
    end

    // Error only in the access phase
    assign o_pslverr = access && !addr_hit;

    always_comb begin
        case (i_paddr)
            REG_RESULT: o_prdata = 32'(result_q);
            REG_STATUS: o_prdata = frame_cnt_q;
            default:    o_prdata = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Weight write strobe and status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wgt_en_q    <= 1'b0;
            result_q    <= '0;
            frame_cnt_q <= '0;
        end else begin
            wgt_en_q <= access && i_pwrite && (i_paddr == REG_WGT);
            if (i_result.valid) begin
                result_q    <= i_result;
                frame_cnt_q <= frame_cnt_q + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && i_pwrite) begin
            wgt_bits_q <= i_pwdata[15:0];
        end
    end

    assign o_wgt = wgt_wr_t'({wgt_en_q, wgt_bits_q});

    a_penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n)
        i_penable |-> $past(i_psel));

endmodule

//--- cnn_tail_cfg.svh
`ifndef CNN_TAIL_CFG_SVH
`define CNN_TAIL_CFG_SVH

// Feature map geometry
`define CT_CH           6
`define CT_POS          8
`define CT_WORD_BYTES   8
`define CT_WORDS        6

// Classifier shape
`define CT_NEURONS      4
`define CT_LANE_NEURONS 2

// Wide enough for 48 products of two int8 values
`define CT_ACC_W        22

// APB address width
`define CT_APB_AW       8

`endif

//--- cnn_tail_pkg.sv
`include "cnn_tail_cfg.svh"

package cnn_tail_pkg;

    typedef logic signed [7:0] int8_t;
    typedef int8_t [`CT_WORD_BYTES-1:0] fm_word_t;
    typedef logic signed [`CT_ACC_W-1:0] acc_t;

    // One beat from the pooling stage
    typedef struct packed {
        logic                   valid;
        logic                   last;
        int8_t [`CT_CH-1:0]     data;
    } pool_beat_t;

    // Buffer word tagged for the lanes
    typedef struct packed {
        logic                           valid;
        logic                           last;
        logic [$clog2(`CT_WORDS)-1:0]   idx;
        fm_word_t                       word;
    } lane_word_t;

    typedef struct packed {
        logic                           valid;
        acc_t [`CT_LANE_NEURONS-1:0]    sum;
    } lane_sum_t;

    // Field order matches pwdata[15:0]
    typedef struct packed {
        logic                                   en;
        logic                                   lane;
        logic                                   neuron;
        logic [$clog2(`CT_CH*`CT_POS)-1:0]      idx;
        int8_t                                  value;
    } wgt_wr_t;

    typedef struct packed {
        logic                               valid;
        logic [$clog2(`CT_NEURONS)-1:0]     cls;
        acc_t                               score;
    } class_result_t;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_READ,
        CS_WAIT,
        CS_DONE
    } class_state_e;

    typedef enum logic [`CT_APB_AW-1:0] {
        REG_WGT    = 8'h00,
        REG_RESULT = 8'h04,
        REG_STATUS = 8'h08
    } apb_reg_e;

endpackage

//--- cnn_tail_top.sv
`timescale 1ns/1ps
`include "cnn_tail_cfg.svh"

module cnn_tail_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_psel,
    input  logic                            i_penable,
    input  logic                            i_pwrite,
    input  logic [`CT_APB_AW-1:0]           i_paddr,
    input  logic [31:0]                     i_pwdata,
    output logic [31:0]                     o_prdata,
    output logic                            o_pready,
    output logic                            o_pslverr,
    input  cnn_tail_pkg::pool_beat_t        i_beat,
    output cnn_tail_pkg::class_result_t     o_result,
    output logic                            o_fc_start
);
    import cnn_tail_pkg::*;

    fm_word_t       fm_word;
    logic [2:0]     fc_fm_addr;
    logic           read_done;
    lane_word_t     lane_word;
    wgt_wr_t        wgt;
    wgt_wr_t        wgt_l0;
    wgt_wr_t        wgt_l1;
    lane_sum_t      sum_l0;
    lane_sum_t      sum_l1;

    pool_fc_buffer u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_beat       (i_beat),
        .i_read_done  (read_done),
        .i_fc_fm_addr (fc_fm_addr),
        .o_fc_start   (o_fc_start),
        .o_fm_word    (fm_word)
    );

    // Lane 0 holds neurons 0 and 1, lane 1 holds neurons 2 and 3
    fc_lane u_lane0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_wgt  (wgt_l0),
        .i_word (lane_word),
        .o_sum  (sum_l0)
    );

    fc_lane u_lane1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_wgt  (wgt_l1),
        .i_word (lane_word),
        .o_sum  (sum_l1)
    );

    fc_classifier u_classifier (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_fc_start   (o_fc_start),
        .i_fm_word    (fm_word),
        .o_fc_fm_addr (fc_fm_addr),
        .o_word       (lane_word),
        .i_wgt        (wgt),
        .o_wgt_l0     (wgt_l0),
        .o_wgt_l1     (wgt_l1),
        .i_sum_l0     (sum_l0),
        .i_sum_l1     (sum_l1),
        .o_result     (o_result),
        .o_read_done  (read_done)
    );

    apb_regs u_apb (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_result  (o_result),
        .o_wgt     (wgt)
    );

endmodule

//--- fc_classifier.sv
`timescale 1ns/1ps
`include "cnn_tail_cfg.svh"

module fc_classifier (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_fc_start,
    input  cnn_tail_pkg::fm_word_t          i_fm_word,
    output logic [2:0]                      o_fc_fm_addr,
    output cnn_tail_pkg::lane_word_t        o_word,
    input  cnn_tail_pkg::wgt_wr_t           i_wgt,
    output cnn_tail_pkg::wgt_wr_t           o_wgt_l0,
    output cnn_tail_pkg::wgt_wr_t           o_wgt_l1,
    input  cnn_tail_pkg::lane_sum_t         i_sum_l0,
    input  cnn_tail_pkg::lane_sum_t         i_sum_l1,
    output cnn_tail_pkg::class_result_t     o_result,
    output logic                            o_read_done
);
    import cnn_tail_pkg::*;

    class_state_e   state_q;
    logic [2:0]     addr_q;
    logic           tag_valid_q;
    logic           tag_last_q;
    logic [2:0]     tag_idx_q;
    logic           sums_ready;
    acc_t           score [`CT_NEURONS];
    logic [1:0]     best_cls;
    acc_t           best_score;
    logic           res_valid_q;
    logic [1:0]     res_cls_q;
    acc_t           res_score_q;

    assign sums_ready = (state_q == CS_WAIT) && i_sum_l0.valid && i_sum_l1.valid;

    //////////////////////////////////////////////////////////////////////
    // Read sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CS_IDLE;
            addr_q  <= '0;
        end else begin
            case (state_q)
                CS_IDLE: begin
                    if (i_fc_start) begin
                        state_q <= CS_READ;
                        addr_q  <= '0;
                    end
                end
                CS_READ: begin
                    addr_q <= addr_q + 3'd1;
                    if (addr_q == 3'(`CT_WORDS - 1)) begin
                        state_q <= CS_WAIT;
                    end
                end
                CS_WAIT: begin
                    if (sums_ready) begin
                        state_q <= CS_DONE;
                    end
                end
                default: state_q <= CS_IDLE;
            endcase
        end
    end

    assign o_fc_fm_addr = addr_q;
    assign o_read_done  = (state_q == CS_DONE);

    // Tag follows the address by the buffer's read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid_q <= 1'b0;
            tag_last_q  <= 1'b0;
            tag_idx_q   <= '0;
        end else begin
            tag_valid_q <= (state_q == CS_READ);
            tag_last_q  <= (state_q == CS_READ) && (addr_q == 3'(`CT_WORDS - 1));
            tag_idx_q   <= addr_q;
        end
    end

    always_comb begin
        o_word.valid = tag_valid_q;
        o_word.last  = tag_last_q;
        o_word.idx   = tag_idx_q;
        o_word.word  = i_fm_word;
    end

    // Weight writes go to one lane only
    always_comb begin
        o_wgt_l0    = i_wgt;
        o_wgt_l1    = i_wgt;
        o_wgt_l0.en = i_wgt.en && !i_wgt.lane;
        o_wgt_l1.en = i_wgt.en && i_wgt.lane;
    end

    //////////////////////////////////////////////////////////////////////
    // Argmax, ties keep the lower index
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        score[0]   = i_sum_l0.sum[0];
        score[1]   = i_sum_l0.sum[1];
        score[2]   = i_sum_l1.sum[0];
        score[3]   = i_sum_l1.sum[1];
        best_cls   = 2'd0;
        best_score = score[0];
        for (int n = 1; n < `CT_NEURONS; n++) begin
            if (score[n] > best_score) begin
                best_cls   = 2'(n);
                best_score = score[n];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= sums_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (sums_ready) begin
            res_cls_q   <= best_cls;
            res_score_q <= best_score;
        end
    end

    always_comb begin
        o_result.valid = res_valid_q;
        o_result.cls   = res_cls_q;
        o_result.score = res_score_q;
    end

    a_lane_sums_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        i_sum_l0.valid == i_sum_l1.valid);

endmodule

//--- fc_lane.sv
`timescale 1ns/1ps
`include "cnn_tail_cfg.svh"

module fc_lane (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cnn_tail_pkg::wgt_wr_t       i_wgt,
    input  cnn_tail_pkg::lane_word_t    i_word,
    output cnn_tail_pkg::lane_sum_t     o_sum
);
    import cnn_tail_pkg::*;

    int8_t              wgt_mem [`CT_LANE_NEURONS][`CT_CH*`CT_POS];
    logic signed [15:0] prod_q [`CT_LANE_NEURONS][`CT_WORD_BYTES];
    logic               s1_valid_q;
    logic               s1_last_q;
    logic               s1_first_q;
    acc_t               word_sum [`CT_LANE_NEURONS];
    acc_t               acc_q [`CT_LANE_NEURONS];
    logic               sum_valid_q;

    // Write enable is already qualified for this lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < `CT_LANE_NEURONS; n++) begin
                for (int i = 0; i < `CT_CH*`CT_POS; i++) begin
                    wgt_mem[n][i] <= '0;
                end
            end
        end else if (i_wgt.en) begin
            wgt_mem[i_wgt.neuron][i_wgt.idx] <= i_wgt.value;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1: products
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int n = 0; n < `CT_LANE_NEURONS; n++) begin
            for (int b = 0; b < `CT_WORD_BYTES; b++) begin
                prod_q[n][b] <= $signed(i_word.word[b]) *
                                $signed(wgt_mem[n][int'(i_word.idx)*`CT_WORD_BYTES + b]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q  <= 1'b0;
            s1_last_q   <= 1'b0;
            s1_first_q  <= 1'b0;
            sum_valid_q <= 1'b0;
        end else begin
            s1_valid_q  <= i_word.valid;
            s1_last_q   <= i_word.valid && i_word.last;
            s1_first_q  <= (i_word.idx == '0);
            sum_valid_q <= s1_valid_q && s1_last_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2: reduce and accumulate
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int n = 0; n < `CT_LANE_NEURONS; n++) begin
            word_sum[n] = '0;
            for (int b = 0; b < `CT_WORD_BYTES; b++) begin
                word_sum[n] = word_sum[n] + acc_t'(prod_q[n][b]);
            end
        end
    end

    // Word 0 restarts the sum
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            for (int n = 0; n < `CT_LANE_NEURONS; n++) begin
                acc_q[n] <= s1_first_q ? word_sum[n] : acc_q[n] + word_sum[n];
            end
        end
    end

    always_comb begin
        o_sum.valid = sum_valid_q;
        for (int n = 0; n < `CT_LANE_NEURONS; n++) begin
            o_sum.sum[n] = acc_q[n];
        end
    end

    a_idx_step: assert property (@(posedge clk) disable iff (!rst_n)
        i_word.valid && (i_word.idx != '0) |->
            $past(i_word.valid) && ($past(i_word.idx) + 3'd1 == i_word.idx));

endmodule

//--- pool_fc_buffer.sv
`timescale 1ns/1ps
`include "cnn_tail_cfg.svh"

module pool_fc_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cnn_tail_pkg::pool_beat_t    i_beat,
    input  logic                        i_read_done,
    input  logic [2:0]                  i_fc_fm_addr,
    output logic                        o_fc_start,
    output cnn_tail_pkg::fm_word_t      o_fm_word
);
    import cnn_tail_pkg::*;

    // Channel-major storage, byte c*8+k is channel c at position k
    int8_t       fm_mem [`CT_CH*`CT_POS];
    logic [3:0]  beat_cnt_q;
    logic        locked_q;
    logic [2:0]  rd_addr_q;
    logic        accept;
    logic        wr_en;
    logic        frame_done;

    // Beats are dropped while the classifier owns the buffer
    assign accept     = i_beat.valid && !locked_q;
    assign wr_en      = accept && (beat_cnt_q < 4'(`CT_POS));
    assign frame_done = accept && i_beat.last && (beat_cnt_q == 4'(`CT_POS - 1));

    //////////////////////////////////////////////////////////////////////
    // Frame tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
            locked_q   <= 1'b0;
            o_fc_start <= 1'b0;
        end else begin
            o_fc_start <= frame_done;
            // Any last beat closes the frame, complete or not
            if (accept) begin
                if (i_beat.last) begin
                    beat_cnt_q <= '0;
                end else if (wr_en) begin
                    beat_cnt_q <= beat_cnt_q + 4'd1;
                end
            end
            if (frame_done) begin
                locked_q <= 1'b1;
            end else if (i_read_done) begin
                locked_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CT_CH*`CT_POS; i++) begin
                fm_mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int c = 0; c < `CT_CH; c++) begin
                fm_mem[c*`CT_POS + int'(beat_cnt_q)] <= i_beat.data[c];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Word read port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= '0;
        end else begin
            rd_addr_q <= i_fc_fm_addr;
        end
    end

    always_comb begin
        for (int b = 0; b < `CT_WORD_BYTES; b++) begin
            o_fm_word[b] = fm_mem[int'(rd_addr_q)*`CT_WORD_BYTES + b];
        end
    end

    a_beat_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> beat_cnt_q <= 4'(`CT_POS));

endmodule

//--- tb.f
+incdir+.
cnn_tail_pkg.sv
pool_fc_buffer.sv
fc_lane.sv
fc_classifier.sv
apb_regs.sv
cnn_tail_top.sv
tb_cnn_tail.sv

//--- tb_cnn_tail.sv
`timescale 1ns/1ps
`include "cnn_tail_cfg.svh"

module tb_cnn_tail;
    import cnn_tail_pkg::*;

    localparam int FM_BYTES = `CT_CH * `CT_POS;
    localparam int N_WGT    = `CT_NEURONS * FM_BYTES;
    // Two weight loads, six frames and some slack
    localparam int TIMEOUT_CYCLES = 2 * N_WGT * 2 + 6 * 40 + 200;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [7:0]     paddr;
    logic [31:0]    pwdata;
    logic [31:0]    prdata;
    logic           pready;
    logic           pslverr;
    pool_beat_t     beat;
    class_result_t  result;
    logic           fc_start;

    // Reference model state
    logic signed [7:0]  wgt_ref [`CT_NEURONS][FM_BYTES];
    logic signed [7:0]  fm_ref [FM_BYTES];
    int                 acc_cnt;
    int                 lock_cnt;
    int                 frames_ref;
    logic [1:0]         exp_cls;
    acc_t               exp_score;
    logic               completing;
    logic               rd_access;
    logic               bad_addr;
    logic               checks_on;
    logic               tie_mode;
    int                 results_seen = 0;
    int                 cycle_cnt = 0;
    integer             seed = 32'h51f4e5b9;

    cnn_tail_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_prdata   (prdata),
        .o_pready   (pready),
        .o_pslverr  (pslverr),
        .i_beat     (beat),
        .o_result   (result),
        .o_fc_start (fc_start)
    );

    always #2 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_fail("Timeout: the run did not finish within the cycle limit");
        end
        if (result.valid) begin
            results_seen <= results_seen + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic compute_expected();
        int sum [`CT_NEURONS];
        int best;
        for (int n = 0; n < `CT_NEURONS; n++) begin
            sum[n] = 0;
            for (int i = 0; i < FM_BYTES; i++) begin
                sum[n] += int'(fm_ref[i]) * int'(wgt_ref[n][i]);
            end
        end
        // Strict compare keeps the lower index on ties
        best = 0;
        for (int n = 1; n < `CT_NEURONS; n++) begin
            if (sum[n] > sum[best]) begin
                best = n;
            end
        end
        exp_cls   = 2'(best);
        exp_score = acc_t'(sum[best]);
    endtask

    assign completing = beat.valid && beat.last && (lock_cnt == 0) &&
                        (acc_cnt == `CT_POS - 1);

    // Buffer stays locked from the last beat until read done, 11 cycles later
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_cnt    <= 0;
            lock_cnt   <= 0;
            frames_ref <= 0;
        end else if (lock_cnt > 0) begin
            lock_cnt <= lock_cnt - 1;
        end else if (beat.valid) begin
            if (acc_cnt < `CT_POS) begin
                for (int c = 0; c < `CT_CH; c++) begin
                    fm_ref[c*`CT_POS + acc_cnt] = beat.data[c];
                end
            end
            if (beat.last) begin
                if (acc_cnt == `CT_POS - 1) begin
                    compute_expected();
                    lock_cnt   <= 11;
                    frames_ref <= frames_ref + 1;
                end
                acc_cnt <= 0;
            end else if (acc_cnt < `CT_POS) begin
                acc_cnt <= acc_cnt + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    assign rd_access = psel && penable && !pwrite;
    assign bad_addr  = !((paddr == REG_WGT) || (paddr == REG_RESULT) || (paddr == REG_STATUS));

    a_start: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        fc_start == $past(completing))
        else report_fail($sformatf("FAIL o_fc_start got %h expected %h",
            $sampled(fc_start), $past(completing)));

    a_result_timing: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        result.valid == $past(fc_start, 10))
        else report_fail($sformatf("FAIL o_result.valid got %h expected %h",
            $sampled(result.valid), $past(fc_start, 10)));

    a_result_cls: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        result.valid |-> result.cls == exp_cls)
        else report_fail($sformatf("FAIL o_result.cls got %h expected %h",
            $sampled(result.cls), $sampled(exp_cls)));

    a_result_score: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        result.valid |-> result.score == exp_score)
        else report_fail($sformatf("FAIL o_result.score got %h expected %h",
            $sampled(result.score), $sampled(exp_score)));

    // Neurons 1 and 3 tie
    a_tie: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        tie_mode && result.valid |-> result.cls == 2'd1)
        else report_fail($sformatf("FAIL o_result.cls got %h expected %h",
            $sampled(result.cls), 2'd1));

    a_rd_result: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        rd_access && (paddr == REG_RESULT) |-> prdata == {7'd0, 1'b1, exp_cls, exp_score})
        else report_fail($sformatf("FAIL o_prdata got %h expected %h",
            $sampled(prdata), {7'd0, 1'b1, exp_cls, exp_score}));

    a_rd_status: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        rd_access && (paddr == REG_STATUS) |-> prdata == 32'(frames_ref))
        else report_fail($sformatf("FAIL o_prdata got %h expected %h",
            $sampled(prdata), 32'(frames_ref)));

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n || !checks_on)
        pslverr == (psel && penable && bad_addr) && pready)
        else report_fail($sformatf("FAIL o_pslverr got %h expected %h",
            $sampled(pslverr), psel && penable && bad_addr));

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        step();
        penable = 1'b1;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_weights(input logic tie);
        logic signed [7:0] value;
        for (int n = 0; n < `CT_NEURONS; n++) begin
            for (int i = 0; i < FM_BYTES; i++) begin
                if (!tie) begin
                    value = 8'($random(seed));
                end else if (n == 1) begin
                    value = 8'(($random(seed) & 63) + 1);
                end else if (n == 3) begin
                    value = wgt_ref[1][i];
                end else begin
                    value = '0;
                end
                wgt_ref[n][i] = value;
                apb_access(1'b1, REG_WGT, {16'h0, 1'(n >> 1), 1'(n & 1), 6'(i), value});
            end
        end
    endtask

    task automatic send_frame(input int n_beats, input int last_at, input logic positive);
        for (int k = 0; k < n_beats; k++) begin
            beat.valid = 1'b1;
            beat.last  = (k == last_at);
            for (int c = 0; c < `CT_CH; c++) begin
                if (positive) begin
                    beat.data[c] = 8'(($random(seed) & 63) + 1);
                end else begin
                    beat.data[c] = 8'($random(seed));
                end
            end
            step();
        end
        beat = '0;
    endtask

    task automatic wait_start();
        @(posedge clk);
        while (!fc_start) begin
            @(posedge clk);
        end
        #0.5;
    endtask

    task automatic wait_result();
        @(posedge clk);
        while (!result.valid) begin
            @(posedge clk);
        end
        #0.5;
    endtask

    initial begin
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        beat      = '0;
        checks_on = 1'b0;
        tie_mode  = 1'b0;
        repeat (2) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        repeat (12) step();
        checks_on = 1'b1;

        load_weights(1'b0);
        send_frame(8, 7, 1'b0);
        wait_result();

        // Early last on beat 5, then a full frame
        send_frame(5, 4, 1'b0);
        repeat (15) step();
        send_frame(8, 7, 1'b0);
        wait_result();

        // Beats during classification are dropped
        send_frame(8, 7, 1'b0);
        wait_start();
        send_frame(8, 7, 1'b0);
        wait_result();
        send_frame(8, 7, 1'b0);
        wait_result();

        apb_access(1'b0, REG_RESULT, '0);
        apb_access(1'b0, REG_STATUS, '0);
        apb_access(1'b0, 8'h0C, '0);
        apb_access(1'b1, 8'h0C, 32'h0000_ffff);

        tie_mode = 1'b1;
        load_weights(1'b1);
        send_frame(8, 7, 1'b1);
        wait_result();
        apb_access(1'b0, REG_STATUS, '0);
        repeat (4) step();

        if (results_seen == 5 && frames_ref == 5) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_fail($sformatf("Wrong number of classified frames: %0d results, %0d frames",
                results_seen, frames_ref));
        end
    end

endmodule
